/* mac_stream_defines.svh */
// Dot-product stream parameters

`ifndef MAC_STREAM_DEFINES_SVH
`define MAC_STREAM_DEFINES_SVH

// ======================================================================
// Datapath sizing
// ======================================================================

// Width of one operand word and of one result
`define MAC_WIDTH 16

// Words per vector, fixed by the eight-input adder tree
`define MAC_VEC_LEN 8

// Pipeline depth in enabled cycles
`define MAC_LATENCY 4

// Result slots, must exceed MAC_LATENCY
`define MAC_FIFO_DEPTH 8

`endif

/* mac_stream_pkg.sv */
// Dot-product stream types

`include "mac_stream_defines.svh"

package mac_stream_pkg;

   // ======================================================================
   // Shared datapath types
   // ======================================================================

   // One serial operand word
   typedef logic [`MAC_WIDTH-1:0] mac_word_t;

   // Full operand vector, slot 0 in the low bits
   typedef mac_word_t [`MAC_VEC_LEN-1:0] mac_vec_t;

   // One wrapped dot-product result
   typedef logic [`MAC_WIDTH-1:0] mac_result_t;

   // Delivered-result counter, wraps at 2^16
   typedef logic [15:0] mac_count_t;

endpackage

/* operand_loader.sv */
// Serial operand loader

`timescale 1ns/1ps

`include "mac_stream_defines.svh"

module operand_loader
   import mac_stream_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  mac_word_t word,
   input  logic      word_valid,
   input  logic      run,
   output mac_vec_t  vec,
   output logic      vec_valid,
   output logic      busy
);

   localparam int IDX_W = $clog2(`MAC_VEC_LEN);

   // Next slot to fill
   logic [IDX_W-1:0] idx;
   // Word accepted this cycle
   logic             accept;
   // Accepted word completes the vector
   logic             last_word;

   assign accept    = word_valid && !vec_valid;
   assign last_word = accept && (idx == IDX_W'(`MAC_VEC_LEN - 1));

   // Held vector blocks new words until the pipeline takes it
   assign busy = vec_valid;

   // ======================================================================
   // Slot index and vector-ready flag
   // ======================================================================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         idx       <= '0;
         vec_valid <= 1'b0;
      end else begin
         // Index wraps back to slot 0 after the last word
         if (accept) begin
            idx <= idx + 1'b1;
         end
         if (last_word) begin
            vec_valid <= 1'b1;
         end else if (run) begin
            // Pipeline captured the vector on this edge
            vec_valid <= 1'b0;
         end
      end
   end

   // ======================================================================
   // Vector slots, filled in arrival order
   // ======================================================================

   always_ff @(posedge clk) begin
      if (accept) begin
         vec[idx] <= word;
      end
   end

   // Outside must respect busy
   a_no_word_while_busy : assert property (
      @(posedge clk) disable iff (rst)
      busy |-> !word_valid
   ) else $error("operand_loader: word strobed while busy");

endmodule

/* mac_tree_pipeline.sv */
// Multiply and adder-tree pipeline

`timescale 1ns/1ps

`include "mac_stream_defines.svh"

module mac_tree_pipeline
   import mac_stream_pkg::*;
(
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  run,
   input  mac_vec_t                              vec,
   input  logic                                  vec_valid,
   output mac_result_t                           res,
   output logic                                  res_valid,
   output logic [$clog2(`MAC_LATENCY + 1)-1:0]   inflight
);

   localparam int INF_W    = $clog2(`MAC_LATENCY + 1);
   localparam int N_PROD   = `MAC_VEC_LEN / 2;
   localparam int N_SUM    = N_PROD / 2;

   // Stage 1 operand register
   mac_vec_t    in_r;
   // Stage 2 pairwise products
   mac_result_t mult_r [N_PROD];
   // Stage 3 first adder level
   mac_result_t add_r  [N_SUM];
   // Stage 4 final sum
   mac_result_t sum_r;

   // Valid bit for each stage, index 0 is stage 1
   logic [`MAC_LATENCY-1:0] valid_r;

   // ======================================================================
   // Datapath, everything frozen while run is low
   // ======================================================================

   always_ff @(posedge clk) begin
      if (run) begin
         in_r <= vec;
         // Products of neighbouring slots, truncated to result width
         for (int i = 0; i < N_PROD; i++) begin
            mult_r[i] <= mac_result_t'(in_r[2*i] * in_r[2*i+1]);
         end
         // First tree level
         for (int i = 0; i < N_SUM; i++) begin
            add_r[i] <= mult_r[2*i] + mult_r[2*i+1];
         end
         // Root of the tree
         sum_r <= add_r[0] + add_r[1];
      end
   end

   assign res = sum_r;

   // ======================================================================
   // Valid tracking
   // ======================================================================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_r <= '0;
      end else if (run) begin
         valid_r <= {valid_r[`MAC_LATENCY-2:0], vec_valid};
      end
   end

   assign res_valid = valid_r[`MAC_LATENCY-1];

   // Occupied stages, used by the FIFO to reserve slots
   always_comb begin
      inflight = '0;
      for (int i = 0; i < `MAC_LATENCY; i++) begin
         inflight = inflight + INF_W'(valid_r[i]);
      end
   end

endmodule

/* result_fifo.sv */
// Result FIFO with in-flight reservation

`timescale 1ns/1ps

`include "mac_stream_defines.svh"

module result_fifo #(
   parameter type item_t = logic [`MAC_WIDTH-1:0],
   parameter int  DEPTH  = `MAC_FIFO_DEPTH
) (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  wr,
   input  item_t                                 wr_data,
   input  logic [$clog2(`MAC_LATENCY + 1)-1:0]   inflight,
   input  logic                                  pop,
   output item_t                                 rd_data,
   output logic                                  empty,
   output logic                                  run
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   // Payload storage
   item_t             mem [DEPTH];

   logic [PTR_W-1:0]  rd_ptr;
   logic [PTR_W-1:0]  wr_ptr;
   logic [CNT_W-1:0]  count;
   logic [CNT_W-1:0]  free_slots;
   logic              full;
   logic              wr_en;
   logic              rd_en;

   assign empty      = (count == '0);
   assign full       = (count == CNT_W'(DEPTH));
   assign free_slots = CNT_W'(DEPTH) - count;

   // Pipeline may advance only if every stage it holds has a slot waiting
   assign run = (free_slots > CNT_W'(inflight));

   // Writes only land on edges where the pipeline moves
   assign wr_en = wr && run;
   assign rd_en = pop && !empty;

   // Oldest entry is always visible
   assign rd_data = mem[rd_ptr];

   // ======================================================================
   // Storage write
   // ======================================================================

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // ======================================================================
   // Pointers and occupancy
   // ======================================================================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Reservation must keep a finished result from meeting a full buffer
   a_no_write_when_full : assert property (
      @(posedge clk) disable iff (rst)
      wr |-> !full
   ) else $error("result_fifo: result arrived with no free slot");

   // Consumer only pops what is there
   a_no_pop_when_empty : assert property (
      @(posedge clk) disable iff (rst)
      pop |-> !empty
   ) else $error("result_fifo: pop while empty");

endmodule

/* result_presenter.sv */
// Result output stage

`timescale 1ns/1ps

module result_presenter
   import mac_stream_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  mac_result_t fifo_data,
   input  logic        fifo_empty,
   output logic        pop,
   input  logic        take,
   output mac_result_t result,
   output logic        result_valid,
   output mac_count_t  result_count
);

   // Output slot frees up this cycle
   logic slot_free;

   assign slot_free = !result_valid || take;

   // Refill from the FIFO whenever the slot is free
   assign pop = slot_free && !fifo_empty;

   // ======================================================================
   // Output register
   // ======================================================================

   always_ff @(posedge clk) begin
      if (pop) begin
         result <= fifo_data;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         result_valid <= 1'b0;
         result_count <= '0;
      end else begin
         if (pop) begin
            result_valid <= 1'b1;
         end else if (take) begin
            result_valid <= 1'b0;
         end
         // One count per delivered result
         if (take && result_valid) begin
            result_count <= result_count + 1'b1;
         end
      end
   end

   // Outside only takes a presented result
   a_take_needs_valid : assert property (
      @(posedge clk) disable iff (rst)
      take |-> result_valid
   ) else $error("result_presenter: take with no result presented");

endmodule

/* mac_stream_top.sv */
// Dot-product stream top level

`timescale 1ns/1ps

`include "mac_stream_defines.svh"

module mac_stream_top
   import mac_stream_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  mac_word_t   word,
   input  logic        word_valid,
   output logic        busy,
   input  logic        take,
   output mac_result_t result,
   output logic        result_valid,
   output mac_count_t  result_count
);

   // Loader to pipeline
   mac_vec_t    vec;
   logic        vec_valid;

   // Pipeline to FIFO
   mac_result_t res;
   logic        res_valid;
   logic [$clog2(`MAC_LATENCY + 1)-1:0] inflight;

   // FIFO back to pipeline and loader
   logic        run;

   // FIFO to presenter
   mac_result_t fifo_data;
   logic        fifo_empty;
   logic        pop;

   operand_loader u_loader (
      .clk        (clk),
      .rst        (rst),
      .word       (word),
      .word_valid (word_valid),
      .run        (run),
      .vec        (vec),
      .vec_valid  (vec_valid),
      .busy       (busy)
   );

   mac_tree_pipeline u_pipeline (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .vec       (vec),
      .vec_valid (vec_valid),
      .res       (res),
      .res_valid (res_valid),
      .inflight  (inflight)
   );

   result_fifo #(
      .item_t (mac_result_t),
      .DEPTH  (`MAC_FIFO_DEPTH)
   ) u_fifo (
      .clk      (clk),
      .rst      (rst),
      .wr       (res_valid),
      .wr_data  (res),
      .inflight (inflight),
      .pop      (pop),
      .rd_data  (fifo_data),
      .empty    (fifo_empty),
      .run      (run)
   );

   result_presenter u_presenter (
      .clk          (clk),
      .rst          (rst),
      .fifo_data    (fifo_data),
      .fifo_empty   (fifo_empty),
      .pop          (pop),
      .take         (take),
      .result       (result),
      .result_valid (result_valid),
      .result_count (result_count)
   );

endmodule

/* mac_stream_tb_tasks.svh */
// Testbench driver and checker tasks

`ifndef MAC_STREAM_TB_TASKS_SVH
`define MAC_STREAM_TB_TASKS_SVH

// ======================================================================
// Reference model
// ======================================================================

// Sum of pairwise products, kept wide and wrapped at the end
function automatic mac_result_t model_dot(input mac_vec_t v);
   logic [31:0] acc;
   acc = '0;
   for (int i = 0; i < `MAC_VEC_LEN / 2; i++) begin
      acc = acc + 32'(v[2*i]) * 32'(v[2*i+1]);
   end
   return mac_result_t'(acc);
endfunction

// ======================================================================
// Compare tasks
// ======================================================================

task automatic check_result(input string name, input mac_result_t got,
                            input mac_result_t exp);
   if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
   end
endtask

task automatic check_count(input string name, input mac_count_t got,
                           input mac_count_t exp);
   if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
   end
endtask

task automatic report_test(input string name, input int errors_before);
   tests_run++;
   if (errors == errors_before) begin
      $display("Test %s: ok", name);
   end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - errors_before);
   end
endtask

// ======================================================================
// Drivers, all called and returning on a falling edge
// ======================================================================

// Slot 0 goes first, one word per accepted edge
task automatic send_vector(input mac_vec_t v);
   int waited;
   for (int i = 0; i < `MAC_VEC_LEN; i++) begin
      waited = 0;
      while (busy && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (busy) begin
         $display("send_vector: busy stayed high, word %0d was never sent", i);
         errors++;
         return;
      end
      word       = v[i];
      word_valid = 1'b1;
      @(negedge clk);
      word_valid = 1'b0;
   end
   expected_q.push_back(model_dot(v));
endtask

// Compare the presented result, then take it
task automatic expect_result();
   int          waited;
   mac_result_t exp;
   waited = 0;
   while (!result_valid && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
   end
   if (!result_valid) begin
      $display("expect_result: no result presented within %0d cycles", WAIT_LIMIT);
      errors++;
      return;
   end
   if (expected_q.size() == 0) begin
      $display("expect_result: a result was presented but none was expected");
      errors++;
   end else begin
      exp = expected_q.pop_front();
      check_result("result", result, exp);
   end
   take = 1'b1;
   @(negedge clk);
   take = 1'b0;
endtask

// Loader held off for STALL_CYCLES edges in a row
task automatic wait_busy_stall();
   int waited;
   int run_len;
   waited  = 0;
   run_len = 0;
   while (run_len < STALL_CYCLES && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
      run_len = busy ? run_len + 1 : 0;
   end
   if (run_len < STALL_CYCLES) begin
      $display("wait_busy_stall: busy never stayed high while results were not taken");
      errors++;
   end
endtask

`endif

/* mac_stream_tb.sv */
// Dot-product stream testbench

`timescale 1ns/1ps

`include "mac_stream_defines.svh"

module mac_stream_tb
   import mac_stream_pkg::*;
();

   // Longest any single wait may last, in cycles
   localparam int WAIT_LIMIT   = 2000;
   // Busy cycles in a row that count as a stalled loader
   localparam int STALL_CYCLES = 32;

   logic        clk;
   logic        rst;
   mac_word_t   word;
   logic        word_valid;
   logic        busy;
   logic        take;
   mac_result_t result;
   logic        result_valid;
   mac_count_t  result_count;

   // Results the DUT still owes, oldest first
   mac_result_t expected_q[$];

   int errors;
   int tests_run;
   int tests_failed;

   mac_stream_top DUT (
      .clk          (clk),
      .rst          (rst),
      .word         (word),
      .word_valid   (word_valid),
      .busy         (busy),
      .take         (take),
      .result       (result),
      .result_valid (result_valid),
      .result_count (result_count)
   );

   // 10 ns clock
   always #5 clk = ~clk;

   `include "mac_stream_tb_tasks.svh"

   // ======================================================================
   // Directed tests
   // ======================================================================

   task automatic test_reset();
      int errors_before;
      errors_before = errors;
      check_flag("busy", busy, 1'b0);
      check_flag("result_valid", result_valid, 1'b0);
      check_count("result_count", result_count, 16'h0000);
      report_test("reset state", errors_before);
   endtask

   task automatic test_single();
      int         errors_before;
      mac_count_t count_before;
      mac_vec_t   v;
      errors_before = errors;
      count_before  = result_count;
      for (int i = 0; i < `MAC_VEC_LEN; i++) begin
         v[i] = mac_word_t'(i + 1);
      end
      // 1*2 + 3*4 + 5*6 + 7*8
      check_result("model_dot", model_dot(v), 16'd100);
      send_vector(v);
      expect_result();
      check_count("result_count", result_count, count_before + 16'd1);
      report_test("single vector", errors_before);
   endtask

   task automatic test_wrap();
      int       errors_before;
      mac_vec_t v;
      errors_before = errors;
      // Each FFFF*FFFF keeps only 0x0001 after the wrap
      v = {`MAC_VEC_LEN{16'hFFFF}};
      check_result("model_dot", model_dot(v), 16'h0004);
      send_vector(v);
      expect_result();
      // Mixed large operands, slot 0 is the last entry
      v = {16'h0F0F, 16'hF00F, 16'h5678, 16'h1234,
           16'h0002, 16'hFFFF, 16'h0002, 16'h8000};
      send_vector(v);
      expect_result();
      report_test("overflow wrap", errors_before);
   endtask

   task automatic test_stream();
      int       errors_before;
      mac_vec_t v;
      errors_before = errors;
      fork
         begin
            for (int n = 0; n < 20; n++) begin
               for (int i = 0; i < `MAC_VEC_LEN; i++) begin
                  v[i] = mac_word_t'($urandom);
               end
               send_vector(v);
            end
         end
         begin
            // Take each result as soon as it shows
            for (int n = 0; n < 20; n++) begin
               expect_result();
            end
         end
      join
      report_test("streaming", errors_before);
   endtask

   task automatic test_backpressure();
      int         errors_before;
      mac_count_t count_before;
      mac_vec_t   v;
      errors_before = errors;
      count_before  = result_count;
      fork
         begin
            for (int n = 0; n < 12; n++) begin
               for (int i = 0; i < `MAC_VEC_LEN; i++) begin
                  v[i] = mac_word_t'($urandom);
               end
               send_vector(v);
            end
         end
         begin
            // No take until the loader is held off
            wait_busy_stall();
            for (int n = 0; n < 12; n++) begin
               expect_result();
            end
         end
      join
      check_count("result_count", result_count, count_before + 16'd12);
      report_test("back-pressure", errors_before);
   endtask

   // ======================================================================
   // Sequence and closing report
   // ======================================================================

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      word       = '0;
      word_valid = 1'b0;
      take       = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      void'($urandom(29));
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      test_reset();
      test_single();
      test_wrap();
      test_stream();
      test_backpressure();
      if (expected_q.size() != 0) begin
         $display("Results never delivered, %0d still expected", expected_q.size());
         errors++;
      end
      $display("Tests %0d, tests with errors %0d, errors %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* mac_stream.f */
+incdir+.
mac_stream_pkg.sv
operand_loader.sv
mac_tree_pipeline.sv
result_fifo.sv
result_presenter.sv
mac_stream_top.sv
mac_stream_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mac_stream_tb
FILELIST  = mac_stream.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = FAIL: see errors above
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
